//--- build.f
logic/decomp_pkg.sv
logic/decomp_ctrl_regs.sv
logic/decomp_mngr.sv
logic/rd_beat_fifo.sv
logic/decomp_subsys_top.sv
testbench/decomp_mem_model.sv
testbench/decomp_tb.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module decomp_tb

run: compile
	./obj_dir/Vdecomp_tb | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "RESULT: PASS" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- testbench/decomp_tb.sv
// testbench for the decompression subsystem, runs APB jobs and checks walk, burst, push and status
`timescale 1ns/1ns
module decomp_tb;
	import decomp_pkg::*;

	localparam logic [4:0] A_CTRL   = 5'h00;
	localparam logic [4:0] A_CPAGE  = 5'h04;
	localparam logic [4:0] A_FREE   = 5'h08;
	localparam logic [4:0] A_STATUS = 5'h0c;
	localparam logic [4:0] A_DCNT   = 5'h10;

	logic        clk_i;
	logic        rst_ni;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [4:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	ar_req_t     ar;
	logic        arready;
	r_resp_t     r;
	logic        rready;
	logic        out_valid;
	data_t       out_data;
	logic        out_ready;
	logic        decomp_start;
	iway_pkt_t   iway_pkt;
	logic        zspg_updated;
	tol_upd_t    tol_upd;
	logic        tbl_update_done;

	// expectations of the running job
	addr_t      exp_cpage;
	addr_t      exp_free;
	int         exp_beats;
	int         exp_walk_n;
	logic [4:0] exp_pg_vld;
	logic       exp_full;
	lst_idx_t   exp_lst;
	size_code_t exp_ifl;

	addr_t ar_log [$]; // accepted read addresses of the job
	int    n_out;
	int    n_start;
	int    n_done;
	int    n_push;
	logic  upd_seen;
	logic  tbl_q;
	int    n_mis;
	int    n_other;

	decomp_subsys_top decomp_subsys_top_i (.*);
	decomp_mem_model decomp_mem_model_i (.*);

	task automatic report_mismatch(input string name, input logic [127:0] exp,
		input logic [127:0] got);
		n_mis++;
		$display("MISMATCH t=%0t %s expected %0h got %0h", $time, name, exp, got);
	endtask

	task automatic report_failure(input string msg);
		n_other++;
		$display("ERROR t=%0t %s", $time, msg);
	endtask

	task automatic expect_eq(input string name, input logic [127:0] exp, input logic [127:0] got);
		assert (got === exp) else report_mismatch(name, exp, got);
	endtask

	a_start_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
		decomp_start |=> !decomp_start)
		else report_failure("decomp_start stayed high for more than one cycle");

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	// stream, strobe and packet monitor
	always @(posedge clk_i) begin
		if (rst_ni) begin
			if (ar.valid && arready) begin
				ar_log.push_back(ar.addr);
			end
			expect_eq("rready", 1'b1, rready); // beats are never refused
			if (out_valid && out_ready) begin
				expect_eq("out_data", {4{exp_cpage + 32'(n_out * 16)}}, out_data);
				n_out++;
			end
			if (decomp_start) begin
				n_start++;
				expect_eq("ar handshakes at decomp_start", exp_walk_n + exp_beats, ar_log.size());
			end
			if (iway_pkt.update && !upd_seen) begin // first packet only
				upd_seen = 1'b1;
				expect_eq("iway_pkt.md.pg_vld", exp_pg_vld, iway_pkt.md.pg_vld);
				expect_eq("iway_pkt.cpage_start", exp_free, iway_pkt.cpage_start);
				expect_eq("iway_pkt.cpage_size", exp_beats * 16, iway_pkt.cpage_size);
				expect_eq("iway_pkt.pp_ifl", exp_full, iway_pkt.pp_ifl);
			end
			if (tol_upd.tbl_update && !tbl_q) begin
				n_push++;
				expect_eq("tol_upd.lst_idx", exp_lst, tol_upd.lst_idx);
				expect_eq("tol_upd.lst_entry", 64'(exp_lst), tol_upd.lst_entry);
				expect_eq("tol_upd.ifl_idx", exp_ifl, tol_upd.ifl_idx);
			end
			tbl_q = tol_upd.tbl_update;
			if (decomp_subsys_top_i.done_pulse) begin
				n_done++;
			end
		end
	end

	task automatic apb_xfer(input logic wr, input logic [4:0] a, input logic [31:0] wd,
		output logic [31:0] rd, output logic err);
		int n;
		@(posedge clk_i);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= a;
		pwdata  <= wd;
		@(posedge clk_i);
		penable <= 1'b1;
		n = 0;
		do begin
			@(posedge clk_i);
			n++;
		end while (!pready && n < 16);
		if (!pready) begin
			report_failure("APB access did not complete");
		end
		rd = prdata;
		err = pslverr;
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	function automatic zspg_md_t make_md(input addr_t iway, input size_code_t code,
		input logic [4:0] vld);
		zspg_md_t md;
		md           = '0;
		md.iway_ptr  = iway;
		md.size_code = code;
		md.pg_vld    = vld;
		return md;
	endfunction

	task automatic fill_chain();
		decomp_mem_model_i.md_addr[0] = 32'h0009_3000; // points back to the iway
		decomp_mem_model_i.md_val[0]  = make_md(32'h0009_2f00, 3'd7, 5'b11111);
		decomp_mem_model_i.md_addr[1] = 32'h0009_2f00;
		decomp_mem_model_i.md_val[1]  = make_md(32'h0009_2f00, 3'd7, 5'b11111);
		decomp_mem_model_i.md_addr[2] = 32'h0005_0000;
		decomp_mem_model_i.md_val[2]  = make_md(32'h0005_0000, 3'd2, 5'b10110);
		decomp_mem_model_i.md_addr[3] = 32'h0006_0000;
		decomp_mem_model_i.md_val[3]  = make_md(32'h0006_0000, 3'd2, 5'b11111);
		decomp_mem_model_i.err_addr   = 32'h0006_0000;
	endtask

	task automatic reset_outputs_low();
		expect_eq("ar.valid", 1'b0, ar.valid);
		expect_eq("decomp_start", 1'b0, decomp_start);
		expect_eq("fifo_flush", 1'b0, decomp_subsys_top_i.fifo_flush);
		expect_eq("iway_pkt.update", 1'b0, iway_pkt.update);
		expect_eq("tol_upd.tbl_update", 1'b0, tol_upd.tbl_update);
		expect_eq("done_pulse", 1'b0, decomp_subsys_top_i.done_pulse);
		expect_eq("busy", 1'b0, decomp_subsys_top_i.busy);
	endtask

	task automatic register_access();
		logic [31:0] rd;
		logic        err;
		apb_xfer(1'b1, A_CPAGE, 32'h1234_5670, rd, err);
		apb_xfer(1'b0, A_CPAGE, 32'h0, rd, err);
		expect_eq("CPAGE_START", 32'h1234_5670, rd);
		apb_xfer(1'b1, A_FREE, 32'habcd_0010, rd, err);
		apb_xfer(1'b0, A_FREE, 32'h0, rd, err);
		expect_eq("FREE_WAY", 32'habcd_0010, rd);
		apb_xfer(1'b0, 5'h14, 32'h0, rd, err);
		expect_eq("pslverr", 1'b1, err);
		apb_xfer(1'b1, 5'h1c, 32'h1, rd, err);
		expect_eq("pslverr", 1'b1, err);
		apb_xfer(1'b0, A_STATUS, 32'h0, rd, err);
		expect_eq("STATUS", 32'h0, rd);
		apb_xfer(1'b0, A_DCNT, 32'h0, rd, err);
		expect_eq("DONE_COUNT", 32'h0, rd);
	endtask

	task automatic run_job(input addr_t cpage, input addr_t free, input int beats,
		input addr_t walk_a, input addr_t walk_b, input int walk_n, input logic [4:0] pg_vld,
		input int pushes, input lst_idx_t lst, input size_code_t ifl);
		logic [31:0] rd;
		logic [31:0] cnt0;
		logic        err;
		int          n;
		exp_cpage  = cpage;
		exp_free   = free;
		exp_beats  = beats;
		exp_walk_n = walk_n;
		exp_pg_vld = pg_vld;
		exp_full   = pushes != 0;
		exp_lst    = lst;
		exp_ifl    = ifl;
		ar_log     = {};
		n_out      = 0;
		n_start    = 0;
		n_done     = 0;
		n_push     = 0;
		upd_seen   = 1'b0;
		apb_xfer(1'b0, A_DCNT, 32'h0, cnt0, err);
		apb_xfer(1'b1, A_CPAGE, cpage, rd, err);
		apb_xfer(1'b1, A_FREE, free, rd, err);
		apb_xfer(1'b1, A_CTRL, 32'h1, rd, err);
		expect_eq("pslverr", 1'b0, err);
		apb_xfer(1'b1, A_CTRL, 32'h1, rd, err);
		expect_eq("pslverr", 1'b1, err); // job already running
		n = 0;
		while (n_done == 0 && n < 4000) begin
			@(posedge clk_i);
			n++;
		end
		if (n_done == 0) begin
			report_failure("job did not end with a done pulse");
		end
		n = 0;
		while (n_out < beats && n < 500) begin // decompressor drains the FIFO
			@(posedge clk_i);
			n++;
		end
		expect_eq("out beats", beats, n_out);
		expect_eq("decomp_start pulses", 1, n_start);
		expect_eq("done pulses", 1, n_done);
		expect_eq("tbl_update packets", pushes, n_push);
		expect_eq("iway_pkt.update seen", 1'b1, upd_seen);
		expect_eq("ar.addr walk 0", walk_a, ar_log[0]);
		if (walk_n > 1) begin
			expect_eq("ar.addr walk 1", walk_b, ar_log[1]);
		end
		apb_xfer(1'b0, A_STATUS, 32'h0, rd, err);
		expect_eq("STATUS", 32'h2, rd);
		apb_xfer(1'b0, A_DCNT, 32'h0, rd, err);
		expect_eq("DONE_COUNT", cnt0 + 32'd1, rd);
		apb_xfer(1'b1, A_STATUS, 32'h2, rd, err);
		apb_xfer(1'b0, A_STATUS, 32'h0, rd, err);
		expect_eq("STATUS", 32'h0, rd);
	endtask

	task automatic bus_error_job();
		logic [31:0] rd;
		logic        err;
		int          n;
		n_done = 0;
		apb_xfer(1'b1, A_CPAGE, 32'h0006_0040, rd, err);
		apb_xfer(1'b1, A_FREE, 32'h000a_2000, rd, err);
		apb_xfer(1'b1, A_CTRL, 32'h1, rd, err);
		rd = '0;
		n = 0;
		while (!rd[2] && n < 50) begin
			apb_xfer(1'b0, A_STATUS, 32'h0, rd, err);
			n++;
		end
		if (!rd[2]) begin
			report_failure("bus error was not reported in STATUS");
		end
		apb_xfer(1'b1, A_CTRL, 32'h1, rd, err);
		expect_eq("pslverr", 1'b1, err); // manager stays busy in BUS_ERROR
		repeat (40) @(posedge clk_i);
		expect_eq("done pulses", 0, n_done);
		apb_xfer(1'b0, A_STATUS, 32'h0, rd, err);
		expect_eq("STATUS", 32'h5, rd);
	endtask

	initial begin
		rst_ni   = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		n_mis    = 0;
		n_other  = 0;
		n_out    = 0;
		n_start  = 0;
		n_done   = 0;
		n_push   = 0;
		upd_seen = 1'b1;
		tbl_q    = 1'b0;
		fill_chain();
		repeat (2) @(posedge clk_i);
		rst_ni <= 1'b1;
		@(posedge clk_i);
		reset_outputs_low();
		register_access();
		// full zspage reached through one chain hop, slot 2 freed
		run_job(32'h0009_3500, 32'h000a_0000, 48, 32'h0009_3000, 32'h0009_2f00, 2,
			5'b11011, 1, 8'h13, 3'd7);
		// partly used zspage, iway at the page base
		run_job(32'h0005_00c0, 32'h000a_1000, 12, 32'h0005_0000, 32'h0, 1,
			5'b10100, 0, 8'h00, 3'd2);
		bus_error_job();
		$display("checks done: %0d mismatches, %0d other errors", n_mis, n_other);
		if (n_mis == 0 && n_other == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- testbench/decomp_mem_model.sv
// testbench memory and peer model, answers reads with stalls and handshakes the page writer and table updater
`timescale 1ns/1ns
module decomp_mem_model (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  decomp_pkg::ar_req_t   ar,
	output logic                  arready,
	output decomp_pkg::r_resp_t   r,
	input  logic                  rready,
	output logic                  out_ready,
	input  decomp_pkg::iway_pkt_t iway_pkt,
	output logic                  zspg_updated,
	input  decomp_pkg::tol_upd_t  tol_upd,
	output logic                  tbl_update_done
);
	import decomp_pkg::*;

	localparam logic [31:0] TAPS = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

	addr_t       md_addr [4]; // metadata chain, filled by the testbench
	zspg_md_t    md_val [4];
	addr_t       err_addr;    // reads here answer with SLVERR
	logic [31:0] lfsr;
	addr_t       pend [$];    // accepted requests waiting for their beat
	addr_t       cur;
	logic [1:0]  rnd;
	logic [1:0]  upd_wait;
	logic [1:0]  tbl_wait;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
	endfunction

	// one step per bit taken
	task automatic take_bits(input int n, output logic [1:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr    = lfsr_step(lfsr);
			bits[i] = lfsr[0];
		end
	endtask

	function automatic data_t beat_at(input addr_t a);
		data_t d;
		d = {4{a}}; // page beats carry their own address
		for (int i = 0; i < 4; i++) begin
			if (md_addr[i] == a) begin
				d = data_t'(md_val[i]);
			end
		end
		if (a[31:12] == LST_BASE[31:12]) begin
			d = {64'd0, 8'hff, 48'd0, a[11:4]}; // list index, owner byte set
		end
		return d;
	endfunction

	always @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			lfsr            = 32'h4261_104f;
			pend            = {};
			arready         <= 1'b0;
			r               <= '0;
			out_ready       <= 1'b0;
			zspg_updated    <= 1'b0;
			tbl_update_done <= 1'b0;
			upd_wait        <= 2'd0;
			tbl_wait        <= 2'd0;
		end else begin
			if (ar.valid && arready) begin
				pend.push_back(ar.addr);
			end
			if (!r.valid || rready) begin
				r.valid <= 1'b0;
				if (pend.size() != 0) begin
					cur = pend.pop_front();
					r.valid <= 1'b1;
					r.data  <= beat_at(cur);
					r.resp  <= (cur == err_addr) ? 2'b10 : 2'b00;
					r.last  <= 1'b1; // single-beat reads
				end
			end
			take_bits(1, rnd);
			arready <= rnd[0];
			take_bits(1, rnd);
			out_ready <= rnd[0];
			zspg_updated <= 1'b0;
			if (iway_pkt.update && !zspg_updated) begin
				if (upd_wait == 2'd0) begin
					zspg_updated <= 1'b1;
					take_bits(2, rnd);
					upd_wait <= rnd; // delay for the next packet
				end else begin
					upd_wait <= upd_wait - 2'd1;
				end
			end
			tbl_update_done <= 1'b0;
			if (tol_upd.tbl_update && !tbl_update_done) begin
				if (tbl_wait == 2'd0) begin
					tbl_update_done <= 1'b1;
					take_bits(2, rnd);
					tbl_wait <= rnd;
				end else begin
					tbl_wait <= tbl_wait - 2'd1;
				end
			end
		end
	end

endmodule

//--- logic/decomp_subsys_top.sv
// top level of the decompression subsystem, joins host registers, manager and beat FIFO
`timescale 1ns/1ns
module decomp_subsys_top #(
	parameter int FIFO_DEPTH = 8,
	parameter int CNT_W      = 16
) (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [4:0]            paddr,
	input  logic [31:0]           pwdata,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr,
	output decomp_pkg::ar_req_t   ar,
	input  logic                  arready,
	input  decomp_pkg::r_resp_t   r,
	output logic                  rready,
	output logic                  out_valid,
	output decomp_pkg::data_t     out_data,
	input  logic                  out_ready,
	output logic                  decomp_start,
	output decomp_pkg::iway_pkt_t iway_pkt,
	input  logic                  zspg_updated,
	output decomp_pkg::tol_upd_t  tol_upd,
	input  logic                  tbl_update_done
);
	import decomp_pkg::*;

	logic                        trigger;
	addr_t                       cpage_start;
	addr_t                       free_way;
	logic                        busy;
	logic                        done_pulse;
	logic                        bus_error;
	logic                        fifo_push;
	logic                        fifo_flush;
	logic [$clog2(FIFO_DEPTH):0] fifo_count;

	decomp_ctrl_regs #(.CNT_W(CNT_W)) decomp_ctrl_regs_i (
		.clk_i, .rst_ni, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .trigger, .cpage_start, .free_way,
		.busy, .done_pulse, .bus_error
	);

	decomp_mngr #(.FIFO_DEPTH(FIFO_DEPTH)) decomp_mngr_i (
		.clk_i, .rst_ni, .trigger, .cpage_start, .free_way,
		.busy, .done_pulse, .bus_error, .ar, .arready, .r, .rready,
		.fifo_push, .fifo_flush, .fifo_count, .decomp_start,
		.iway_pkt, .zspg_updated, .tol_upd, .tbl_update_done
	);

	// beats go out only through the FIFO
	rd_beat_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rd_beat_fifo_i (
		.clk_i, .rst_ni, .flush(fifo_flush), .push(fifo_push), .push_data(r.data),
		.out_valid, .out_data, .out_ready, .count(fifo_count)
	);

endmodule

//--- logic/rd_beat_fifo.sv
// beat FIFO between the read channel and the decompressor stream, flushed per job
`timescale 1ns/1ns
module rd_beat_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                        clk_i,
	input  logic                        rst_ni,
	input  logic                        flush,
	input  logic                        push,
	input  decomp_pkg::data_t           push_data,
	output logic                        out_valid,
	output decomp_pkg::data_t           out_data,
	input  logic                        out_ready,
	output logic [$clog2(FIFO_DEPTH):0] count
);
	import decomp_pkg::*;

	localparam int PW = $clog2(FIFO_DEPTH);

	data_t         mem [FIFO_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic          pop;

	assign out_valid = count != '0;
	assign out_data  = mem[rd_ptr];
	assign pop       = out_valid & out_ready;

	always_ff @(posedge clk_i) begin
		if (push && !flush) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0; // empty on the next cycle
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + PW'(push); // wraps at power-of-two depth
			rd_ptr <= rd_ptr + PW'(pop);
			count  <= count + (PW + 1)'(push) - (PW + 1)'(pop);
		end
	end

	a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
		push && !flush |-> count < FIFO_DEPTH)
		else $error("beat FIFO overflow");

	// count never wraps past full or below empty
	a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
		count <= FIFO_DEPTH)
		else $error("beat FIFO count out of range");

endmodule

//--- logic/decomp_mngr.sv
// decompression manager FSM, walks zspage metadata, frees the slot, streams the page, pushes free list
`timescale 1ns/1ns
module decomp_mngr #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                        clk_i,
	input  logic                        rst_ni,
	input  logic                        trigger,
	input  decomp_pkg::addr_t           cpage_start,
	input  decomp_pkg::addr_t           free_way,
	output logic                        busy,
	output logic                        done_pulse,
	output logic                        bus_error,
	output decomp_pkg::ar_req_t         ar,
	input  logic                        arready,
	input  decomp_pkg::r_resp_t         r,
	output logic                        rready,
	output logic                        fifo_push,
	output logic                        fifo_flush,
	input  logic [$clog2(FIFO_DEPTH):0] fifo_count,
	output logic                        decomp_start,
	output decomp_pkg::iway_pkt_t       iway_pkt,
	input  logic                        zspg_updated,
	output decomp_pkg::tol_upd_t        tol_upd,
	input  logic                        tbl_update_done
);
	import decomp_pkg::*;

	localparam int CW = $clog2(FIFO_DEPTH) + 1;

	mngr_state_e   state;
	addr_t         cpage_q;    // job latched at trigger
	addr_t         free_q;
	burst_cnt_t    burst_left; // reads still to issue
	logic [CW-1:0] outst;      // issued but not returned
	logic [CW:0]   occupancy;
	logic          in_burst;
	logic          r_fire;
	logic          r_err;
	logic          can_issue;
	zspg_md_t      beat_md;
	lst_idx_t      lst_idx;
	addr_t         lst_addr;

	assign rready     = 1'b1; // FIFO space reserved before issue
	assign r_fire     = r.valid & rready;
	assign r_err      = r.resp != 2'b00;
	assign in_burst   = state inside {BURST_START, BURST};
	assign fifo_push  = r_fire & in_burst & !r_err;
	assign fifo_flush = state == FLUSH_FIFO;
	assign busy       = state != IDLE;
	assign done_pulse = state == DONE;
	assign bus_error  = state == BUS_ERROR;
	assign beat_md    = zspg_md_t'(r.data);

	assign occupancy = {1'b0, outst} + {1'b0, fifo_count};
	assign can_issue = (!ar.valid || arready) && burst_left != '0 && occupancy < FIFO_DEPTH;

	// list entry of the zspage, indexed by its 4 KB frame
	assign lst_idx  = lst_idx_t'((iway_pkt.md.iway_ptr - {LST_BASE[31:12], 12'h000}) >> 12)
		+ lst_idx_t'(1);
	assign lst_addr = LST_BASE + {20'h0, lst_idx, 4'h0};

	always_ff @(posedge clk_i) begin
		if (state == IDLE && trigger) begin
			cpage_q <= cpage_start;
			free_q  <= free_way;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state        <= IDLE;
			ar           <= '0;
			iway_pkt     <= '0;
			tol_upd      <= '0;
			decomp_start <= 1'b0;
			burst_left   <= '0;
			outst        <= '0;
		end else begin
			decomp_start <= 1'b0;
			if (ar.valid && arready) begin
				ar.valid <= 1'b0;
			end
			case (state)
				IDLE: begin
					if (trigger) begin
						state <= REQ_IWAY;
					end
				end
				REQ_IWAY: begin
					ar.valid <= 1'b1;
					ar.addr  <= {cpage_q[31:12], 12'h000}; // metadata at page base
					state    <= FETCH_IWAY;
				end
				FETCH_IWAY: begin
					if (r_fire) begin
						if (r_err) begin
							state <= BUS_ERROR;
						end else if (beat_md.iway_ptr == ar.addr) begin // self pointer marks iway
							iway_pkt.md     <= beat_md;
							iway_pkt.pp_ifl <= &beat_md.pg_vld;
							state           <= SET_FREE;
						end else begin
							ar.valid <= 1'b1;
							ar.addr  <= beat_md.iway_ptr;
						end
					end
				end
				SET_FREE: begin
					iway_pkt.md          <= free_slot(iway_pkt.md, cpage_q);
					iway_pkt.cpage_size  <= cpage_size_tbl[iway_pkt.md.size_code];
					iway_pkt.cpage_start <= free_q;
					burst_left <= burst_cnt_t'(cpage_size_tbl[iway_pkt.md.size_code] >> 4);
					outst      <= '0;
					state      <= FLUSH_FIFO;
				end
				FLUSH_FIFO: state <= BURST_START;
				BURST_START: begin
					ar.valid   <= 1'b1; // FIFO just flushed, room for one
					ar.addr    <= cpage_q;
					burst_left <= burst_left - 1'b1;
					outst      <= CW'(1);
					state      <= BURST;
				end
				BURST: begin
					if (can_issue) begin
						ar.valid   <= 1'b1;
						ar.addr    <= ar.addr + 32'd16;
						burst_left <= burst_left - 1'b1;
					end
					outst <= outst + CW'(can_issue) - CW'(r_fire);
					if (r_fire && r_err) begin
						state <= BUS_ERROR;
					end else if (burst_left == '0 && outst == '0) begin
						decomp_start    <= 1'b1;
						iway_pkt.update <= 1'b1;
						state           <= DECOMP_WAIT;
					end
				end
				DECOMP_WAIT: begin
					if (zspg_updated) begin
						iway_pkt.update <= 1'b0;
						if (iway_pkt.pp_ifl) begin
							ar.valid <= 1'b1;
							ar.addr  <= lst_addr;
							state    <= FETCH_LST;
						end else begin
							state <= DONE;
						end
					end
				end
				FETCH_LST: begin
					if (r_fire) begin
						if (r_err) begin
							state <= BUS_ERROR;
						end else begin
							tol_upd.lst_entry <= r.data[63:0];
							state             <= DECODE_LST;
						end
					end
				end
				DECODE_LST: begin
					tol_upd.lst_entry  <= tol_upd.lst_entry & ~LST_OWNER_MASK; // drop owner
					tol_upd.lst_idx    <= lst_idx;
					tol_upd.ifl_idx    <= iway_pkt.md.size_code;
					tol_upd.tbl_update <= 1'b1;
					state              <= PUSH_IFL;
				end
				PUSH_IFL: begin
					if (tbl_update_done) begin
						tol_upd.tbl_update <= 1'b0;
						state              <= DONE;
					end
				end
				DONE:      state <= IDLE;
				BUS_ERROR: state <= BUS_ERROR; // held until reset
				default:   state <= IDLE;
			endcase
		end
	end

	a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
		ar.valid && !arready |=> ar.valid && $stable(ar.addr))
		else $error("ar changed while stalled");

	a_r_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
		r.valid |-> r.last)
		else $error("read beat without last");

	a_push_room: assert property (@(posedge clk_i) disable iff (!rst_ni)
		fifo_push |-> fifo_count < FIFO_DEPTH)
		else $error("push into full beat FIFO");

endmodule

//--- logic/decomp_ctrl_regs.sv
// APB register block holding the decompression job, its trigger, status and done counter
`timescale 1ns/1ns
module decomp_ctrl_regs #(
	parameter int CNT_W = 16
) (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [4:0]        paddr,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr,
	output logic              trigger,
	output decomp_pkg::addr_t cpage_start,
	output decomp_pkg::addr_t free_way,
	input  logic              busy,
	input  logic              done_pulse,
	input  logic              bus_error
);
	localparam logic [4:0] ADDR_CTRL   = 5'h00;
	localparam logic [4:0] ADDR_CPAGE  = 5'h04;
	localparam logic [4:0] ADDR_FREE   = 5'h08;
	localparam logic [4:0] ADDR_STATUS = 5'h0c;
	localparam logic [4:0] ADDR_DCNT   = 5'h10;

	logic             access;
	logic             addr_ok;
	logic             ctrl_reject;
	logic             wr_ok;
	logic             done_q;
	logic [CNT_W-1:0] done_cnt;

	assign access      = psel & penable;
	assign addr_ok     = paddr inside {ADDR_CTRL, ADDR_CPAGE, ADDR_FREE, ADDR_STATUS, ADDR_DCNT};
	assign ctrl_reject = pwrite && paddr == ADDR_CTRL && (busy || trigger); // job still pending
	assign pready      = 1'b1; // zero wait states
	assign pslverr     = access & (!addr_ok | ctrl_reject);
	assign wr_ok       = access & pwrite & !pslverr;

	always_comb begin
		prdata = '0;
		case (paddr)
			ADDR_CPAGE:  prdata = cpage_start;
			ADDR_FREE:   prdata = free_way;
			ADDR_STATUS: prdata = {29'd0, bus_error, done_q, busy};
			ADDR_DCNT:   prdata = 32'(done_cnt);
			default:     prdata = '0; // CTRL reads as zero
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			trigger     <= 1'b0;
			cpage_start <= '0;
			free_way    <= '0;
			done_q      <= 1'b0;
			done_cnt    <= '0;
		end else begin
			trigger <= wr_ok && paddr == ADDR_CTRL && pwdata[0]; // one-cycle pulse
			if (wr_ok && paddr == ADDR_CPAGE) begin
				cpage_start <= pwdata;
			end
			if (wr_ok && paddr == ADDR_FREE) begin
				free_way <= pwdata;
			end
			// completion wins over a clear in the same cycle
			if (done_pulse) begin
				done_q   <= 1'b1;
				done_cnt <= done_cnt + 1'b1;
			end else if (wr_ok && paddr == ADDR_STATUS && pwdata[1]) begin
				done_q <= 1'b0;
			end
		end
	end

endmodule

//--- logic/decomp_pkg.sv
// shared types, metadata layout, size table and slot-free helper for the decompression subsystem
package decomp_pkg;

	typedef logic [31:0]  addr_t;       // memory byte address
	typedef logic [127:0] data_t;       // one 16-byte read beat
	typedef logic [7:0]   lst_idx_t;
	typedef logic [2:0]   size_code_t;
	typedef logic [5:0]   burst_cnt_t;
	typedef logic [9:0]   cpage_size_t; // compressed page size in bytes

	localparam int MAX_SLOTS = 5; // page slots per zspage

	// list entry table, one beat per entry, 256 entries up to 0x0008_1000
	localparam addr_t LST_BASE = 32'h0008_0000;
	localparam logic [63:0] LST_OWNER_MASK = 64'hff00_0000_0000_0000; // owner in bits 63:56

	localparam cpage_size_t cpage_size_tbl [8] = '{
		10'd64, 10'd128, 10'd192, 10'd256, 10'd384, 10'd512, 10'd640, 10'd768
	};

	typedef struct packed {
		logic [55:0]          rsvd;        // 127:72
		logic [MAX_SLOTS-1:0] pg_vld;      // 71:67
		size_code_t           size_code;   // 66:64
		addr_t                nxt_way_ptr; // 63:32
		addr_t                iway_ptr;    // 31:0
	} zspg_md_t;

	typedef struct packed {
		zspg_md_t    md;
		cpage_size_t cpage_size;
		addr_t       cpage_start; // new location of the page
		logic        update;
		logic        pp_ifl;      // zspage was full before this free
	} iway_pkt_t;

	typedef struct packed {
		logic  valid;
		addr_t addr;
	} ar_req_t;

	typedef struct packed {
		logic       valid;
		data_t      data;
		logic [1:0] resp;
		logic       last;
	} r_resp_t;

	typedef struct packed {
		logic        tbl_update;
		lst_idx_t    lst_idx;
		logic [63:0] lst_entry;
		size_code_t  ifl_idx;
	} tol_upd_t;

	typedef enum logic [3:0] {
		IDLE, REQ_IWAY, FETCH_IWAY, SET_FREE, FLUSH_FIFO, BURST_START, BURST,
		DECOMP_WAIT, FETCH_LST, DECODE_LST, PUSH_IFL, DONE, BUS_ERROR
	} mngr_state_e;

	// clears the valid bit of the first slot whose address is cpage_start
	function automatic zspg_md_t free_slot(zspg_md_t md, addr_t cpage_start);
		zspg_md_t res;
		addr_t    slot_addr;
		logic     hit;
		res = md;
		hit = 1'b0;
		for (int k = 0; k < MAX_SLOTS; k++) begin
			slot_addr = md.iway_ptr + addr_t'(k) * addr_t'(cpage_size_tbl[md.size_code]);
			if (!hit && slot_addr == cpage_start) begin
				res.pg_vld[k] = 1'b0;
				hit = 1'b1;
			end
		end
		return res;
	endfunction

endpackage
